//--- Makefile
# Verilator build and run of the sine stimulus testbench
VERILATOR ?= verilator
TOP       ?= wfg_stim_sine_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "failure reported, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/wfg_reg_pkg.sv
// sine stimulus register map
// wishbone addresses, reset values and the configuration handed to the datapath
package wfg_reg_pkg;

    // word addresses, compared zero-extended against the bus address
    localparam logic [11:0] adr_ctrl    = 12'h010;
    localparam logic [11:0] adr_inc     = 12'h018;
    localparam logic [11:0] adr_gain    = 12'h01C;
    localparam logic [11:0] adr_offset  = 12'h020;
    localparam logic [11:0] adr_reginfo = 12'hFF8;
    localparam logic [11:0] adr_id      = 12'hFFC;

    // enable comes up cleared
    localparam logic        ctrl_en_rst = 1'b0;

    // one turn in 16 samples
    localparam logic [15:0] inc_rst     = 16'h1000;

    // unity gain, 0x4000 is 1.0
    localparam logic [15:0] gain_rst    = 16'h4000;

    localparam logic [17:0] offset_rst  = 18'h00000;

    // identification, read only
    localparam logic [7:0]  peripheral_type = 8'h01;
    localparam logic [7:0]  version         = 8'h01;
    localparam logic [17:0] reginfo_date    = 18'd210722;

    // live configuration
    // en and inc go to the rotator, gain and offset to the scaling stage
    typedef struct packed {
        // run the generator
        logic               en;
        // phase step per sample
        logic        [15:0] inc;
        // Q2.14 gain
        logic        [15:0] gain;
        // added after scaling, in sample units
        logic signed [17:0] offset;
    } wfg_cfg_t;

endpackage

//--- common/wfg_sine_pkg.sv
// sine datapath types and CORDIC constants
// shared by the rotator and the scaling stage
package wfg_sine_pkg;

    // full turn is 2^16
    typedef logic [15:0] phase_t;

    // Q1.16, +1.0 is 65536
    typedef logic signed [17:0] sine_t;

    // scaled output sample
    typedef struct packed {
        logic signed [17:0] data;
    } sample_t;

    // one iteration per clock
    localparam int cordic_iter = 16;

    // extra fraction bits kept in x and y during rotation
    localparam int cordic_guard = 2;

    // atan(2^-i) in phase units, 8192 is 45 degrees
    localparam logic [0:15][15:0] cordic_atan = '{
        16'd8192, 16'd4836, 16'd2555, 16'd1297,
        16'd651,  16'd326,  16'd163,  16'd81,
        16'd41,   16'd20,   16'd10,   16'd5,
        16'd3,    16'd1,    16'd1,    16'd0
    };

    // 1/K in Q1.16, x start value so the result lands at unit amplitude
    localparam int cordic_k_init = 39797;

    // gain is Q2.14
    localparam int gain_shift = 14;

    // 18-bit signed limits
    localparam int sample_max = 131071;
    localparam int sample_min = -131072;

endpackage

//--- logic/wfg_stim_sine_scale.sv
// sine scaling stage
// gain, offset and saturation into a registered valid/ready output
`timescale 1ns/10ps

module wfg_stim_sine_scale (
    input  logic                  wb_clk_i,
    input  logic                  wb_rst_i,
    input  wfg_sine_pkg::sine_t   sin_i,
    input  logic                  sin_valid_i,
    input  logic [15:0]           gain_i,
    input  logic signed [17:0]    offset_i,
    output logic                  sin_ready_o,
    output wfg_sine_pkg::sample_t sample_o,
    output logic                  sample_valid_o,
    input  logic                  sample_ready_i
);

    logic signed [33:0] prod;
    logic signed [34:0] sum;
    logic signed [17:0] sat;

    // gain is unsigned, zero-extend before the signed multiply
    assign prod = sin_i * $signed({1'b0, gain_i});

    // drop the Q2.14 fraction, then offset
    assign sum = (prod >>> wfg_sine_pkg::gain_shift) + offset_i;

    // clamp to the 18-bit range
    always_comb begin
        if (sum > wfg_sine_pkg::sample_max) begin
            sat = 18'(wfg_sine_pkg::sample_max);
        end else if (sum < wfg_sine_pkg::sample_min) begin
            sat = 18'(wfg_sine_pkg::sample_min);
        end else begin
            sat = sum[17:0];
        end
    end

    // take a new input when empty or draining this cycle
    assign sin_ready_o = !sample_valid_o || sample_ready_i;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            sample_valid_o <= 1'b0;
        end else if (sin_ready_o) begin
            sample_valid_o <= sin_valid_i;
        end
    end

    // output data
    always_ff @(posedge wb_clk_i) begin
        if (sin_valid_i && sin_ready_o) begin
            sample_o.data <= sat;
        end
    end

    // stalled output keeps its value
    a_sample_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        sample_valid_o && !sample_ready_i |=> sample_valid_o && $stable(sample_o));

endmodule

//--- testbench/wfg_stim_sine_tb.sv
// sine stimulus generator testbench
// wishbone configuration, bit-exact sine model and sample stream checker
`timescale 1ns/10ps

module wfg_stim_sine_tb;

    localparam int clk_half  = 20;
    localparam int n_default = 40;
    localparam int n_gain    = 40;
    localparam int n_bp      = 60;
    localparam int n_restart = 40;
    localparam int n_samples = n_default + 2 * n_gain + n_bp + n_restart;
    // wishbone accesses issued by the sequence below
    localparam int n_bus       = 43;
    localparam int cycle_limit = n_samples * 40 + n_bus * 4 + 200;
    // one sample takes about cordic_iter + 4 cycles
    // twice that without valid means nothing is left in flight
    localparam int drain_window = 2 * (wfg_sine_pkg::cordic_iter + 4);
    localparam int ack_limit    = 16;

    logic                  wb_clk_i;
    logic                  wb_rst_i;
    logic                  wbs_stb_i;
    logic                  wbs_cyc_i;
    logic                  wbs_we_i;
    logic [3:0]            wbs_sel_i;
    logic [31:0]           wbs_dat_i;
    logic [31:0]           wbs_adr_i;
    logic                  wbs_ack_o;
    logic [31:0]           wbs_dat_o;
    wfg_sine_pkg::sample_t sample_o;
    logic                  sample_valid_o;
    logic                  sample_ready_i;

    // model phase and the configuration in force
    logic [15:0]        m_phase  = 16'h0000;
    logic [15:0]        m_inc    = wfg_reg_pkg::inc_rst;
    logic [15:0]        m_gain   = wfg_reg_pkg::gain_rst;
    logic signed [17:0] m_offset = wfg_reg_pkg::offset_rst;

    int                 sample_errors = 0;
    int                 bus_errors    = 0;
    int                 checked       = 0;
    int                 holds         = 0;
    int                 sat_hi        = 0;
    int                 sat_lo        = 0;
    int                 cycle_cnt     = 0;
    int                 holds_before;
    logic               ready_random  = 1'b0;
    logic               hold_pending  = 1'b0;
    logic signed [17:0] hold_data;
    logic signed [17:0] exp_data;

    wfg_stim_sine_top #(
        .BUSW(32)
    ) wfg_stim_sine_top_i (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .wbs_stb_i     (wbs_stb_i),
        .wbs_cyc_i     (wbs_cyc_i),
        .wbs_we_i      (wbs_we_i),
        .wbs_sel_i     (wbs_sel_i),
        .wbs_dat_i     (wbs_dat_i),
        .wbs_adr_i     (wbs_adr_i),
        .wbs_ack_o     (wbs_ack_o),
        .wbs_dat_o     (wbs_dat_o),
        .sample_o      (sample_o),
        .sample_valid_o(sample_valid_o),
        .sample_ready_i(sample_ready_i)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #clk_half wb_clk_i = ~wb_clk_i;
    end

    // expected sample for one phase
    // quarter-wave fold, 16 CORDIC steps, sign, then Q2.14 gain, offset and clamp
    function automatic logic signed [17:0] ref_sample(input logic [15:0] phase,
                                                      input logic [15:0] gain,
                                                      input logic signed [17:0] offset);
        logic signed [19:0] x;
        logic signed [19:0] y;
        logic signed [19:0] x_next;
        logic signed [17:0] z;
        logic signed [17:0] step;
        logic signed [19:0] y_rnd;
        logic signed [17:0] sine;
        longint             scaled;
        int                 i;
        // odd quadrants mirror about 90 degrees
        if (phase[14]) begin
            z = 18'sd16384 - $signed({4'b0000, phase[13:0]});
        end else begin
            z = $signed({4'b0000, phase[13:0]});
        end
        x = 20'(wfg_sine_pkg::cordic_k_init <<< wfg_sine_pkg::cordic_guard);
        y = '0;
        for (i = 0; i < wfg_sine_pkg::cordic_iter; i++) begin
            step = $signed({2'b00, wfg_sine_pkg::cordic_atan[i]});
            if (z >= 0) begin
                x_next = x - (y >>> i);
                y      = y + (x >>> i);
                z      = z - step;
            end else begin
                x_next = x + (y >>> i);
                y      = y - (x >>> i);
                z      = z + step;
            end
            x = x_next;
        end
        // round away the guard bits
        y_rnd = (y + 20'(1 << (wfg_sine_pkg::cordic_guard - 1))) >>> wfg_sine_pkg::cordic_guard;
        // lower half of the turn is negative
        if (phase[15]) begin
            y_rnd = -y_rnd;
        end
        sine   = y_rnd[17:0];
        scaled = (longint'(sine) * longint'(gain)) >>> wfg_sine_pkg::gain_shift;
        scaled = scaled + longint'(offset);
        if (scaled > wfg_sine_pkg::sample_max) begin
            scaled = wfg_sine_pkg::sample_max;
        end else if (scaled < wfg_sine_pkg::sample_min) begin
            scaled = wfg_sine_pkg::sample_min;
        end
        return 18'(scaled);
    endfunction

    // one classic cycle, strobe held until ack, then one idle cycle
    task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int acks;
        int waits;
        acks  = 0;
        waits = 0;
        rdat  = '0;
        @(posedge wb_clk_i);
        wbs_adr_i <= {20'h00000, adr};
        wbs_dat_i <= wdat;
        wbs_we_i  <= we;
        wbs_sel_i <= 4'hF;
        wbs_stb_i <= 1'b1;
        wbs_cyc_i <= 1'b1;
        while (acks == 0 && waits < ack_limit) begin
            @(posedge wb_clk_i);
            waits++;
            if (wbs_ack_o) begin
                acks++;
                rdat = wbs_dat_o;
            end
        end
        wbs_stb_i <= 1'b0;
        wbs_cyc_i <= 1'b0;
        wbs_we_i  <= 1'b0;
        // ack must be gone by the idle cycle
        @(posedge wb_clk_i);
        if (wbs_ack_o) begin
            acks++;
        end
        if (acks != 1) begin
            bus_errors++;
            $display("bus access to 0x%03h saw %0d acks instead of exactly one", adr, acks);
        end
    endtask

    task automatic wb_write(input logic [11:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [11:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, 32'h0, dat);
    endtask

    task automatic expect_read(input logic [11:0] adr, input logic [31:0] exp, input string what);
        logic [31:0] got;
        wb_read(adr, got);
        if (got !== exp) begin
            bus_errors++;
            $display("ERROR %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // returns on a falling edge once the output has been quiet long enough
    task automatic wait_drained();
        int quiet;
        quiet = 0;
        while (quiet < drain_window) begin
            @(negedge wb_clk_i);
            if (sample_valid_o) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic wait_samples(input int n);
        int target;
        @(negedge wb_clk_i);
        target = checked + n;
        while (checked < target) begin
            @(negedge wb_clk_i);
        end
    endtask

    // stop, let the last sample out, load new settings and run again
    task automatic configure(input logic [15:0] inc, input logic [15:0] gain,
                             input logic signed [17:0] offset);
        wb_write(wfg_reg_pkg::adr_ctrl, 32'h0);
        wait_drained();
        // idle and disabled, phase is back at zero
        m_phase  = 16'h0000;
        m_inc    = inc;
        m_gain   = gain;
        m_offset = offset;
        wb_write(wfg_reg_pkg::adr_inc, {16'h0000, inc});
        wb_write(wfg_reg_pkg::adr_gain, {16'h0000, gain});
        wb_write(wfg_reg_pkg::adr_offset, {{14{offset[17]}}, offset});
        wb_write(wfg_reg_pkg::adr_ctrl, 32'h1);
    endtask

    // output ready, always set or random
    initial begin
        logic [31:0] rnd;
        rnd = $urandom(52166);
        sample_ready_i = 1'b1;
        forever begin
            @(posedge wb_clk_i);
            rnd = $urandom;
            if (ready_random) begin
                sample_ready_i <= rnd[0];
            end else begin
                sample_ready_i <= 1'b1;
            end
        end
    end

    // compare every transferred sample, watch stalled ones
    always @(posedge wb_clk_i) begin
        if (!wb_rst_i) begin
            if (hold_pending) begin
                if (!sample_valid_o || sample_o.data !== hold_data) begin
                    sample_errors++;
                    $display("ERROR %0t: stalled sample %0d was not held", $time, hold_data);
                end
            end
            hold_pending = 1'b0;
            if (sample_valid_o && sample_ready_i) begin
                exp_data = ref_sample(m_phase, m_gain, m_offset);
                if (sample_o.data !== exp_data) begin
                    sample_errors++;
                    $display("ERROR %0t: sample %0d at phase 0x%04h is %0d, expected %0d",
                             $time, checked, m_phase, sample_o.data, exp_data);
                end
                if (sample_o.data == 18'(wfg_sine_pkg::sample_max)) begin
                    sat_hi++;
                end
                if (sample_o.data == 18'(wfg_sine_pkg::sample_min)) begin
                    sat_lo++;
                end
                m_phase = m_phase + m_inc;
                checked++;
            end else if (sample_valid_o) begin
                hold_pending = 1'b1;
                hold_data    = sample_o.data;
                holds++;
            end
        end
    end

    // run limit
    always @(posedge wb_clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("%0d samples checked, %0d sample errors, %0d bus errors",
                     checked, sample_errors, bus_errors);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        wb_rst_i  = 1'b1;
        wbs_stb_i = 1'b0;
        wbs_cyc_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = 4'h0;
        wbs_dat_i = 32'h0;
        wbs_adr_i = 32'h0;
        repeat (3) @(posedge wb_clk_i);
        wb_rst_i <= 1'b0;

        // reset values and identification
        expect_read(wfg_reg_pkg::adr_ctrl, {31'h0, wfg_reg_pkg::ctrl_en_rst}, "CTRL");
        expect_read(wfg_reg_pkg::adr_inc, {16'h0, wfg_reg_pkg::inc_rst}, "INC");
        expect_read(wfg_reg_pkg::adr_gain, {16'h0, wfg_reg_pkg::gain_rst}, "GAIN");
        expect_read(wfg_reg_pkg::adr_offset, {14'h0, wfg_reg_pkg::offset_rst}, "OFFSET");
        expect_read(wfg_reg_pkg::adr_reginfo, {14'h0, wfg_reg_pkg::reginfo_date}, "REGINFO");
        expect_read(wfg_reg_pkg::adr_id,
                    {16'h0, wfg_reg_pkg::version, wfg_reg_pkg::peripheral_type}, "ID");
        expect_read(12'h004, 32'h0, "unmapped");

        // default sine, phases n * 0x1000
        wb_write(wfg_reg_pkg::adr_ctrl, 32'h1);
        wait_samples(n_default);

        // field writes with junk in the upper bits
        wb_write(wfg_reg_pkg::adr_ctrl, 32'h0);
        wait_drained();
        m_phase  = 16'h0000;
        m_inc    = 16'h0321;
        m_gain   = 16'h2A00;
        m_offset = 18'sd2748;
        wb_write(wfg_reg_pkg::adr_inc, 32'hDEAD_0321);
        wb_write(wfg_reg_pkg::adr_gain, 32'h5A5A_2A00);
        wb_write(wfg_reg_pkg::adr_offset, 32'hFFFC_0ABC);
        expect_read(wfg_reg_pkg::adr_inc, 32'h0000_0321, "INC");
        expect_read(wfg_reg_pkg::adr_gain, 32'h0000_2A00, "GAIN");
        expect_read(wfg_reg_pkg::adr_offset, 32'h0000_0ABC, "OFFSET");
        wb_write(wfg_reg_pkg::adr_ctrl, 32'hFFFF_FFFF);
        expect_read(wfg_reg_pkg::adr_ctrl, 32'h0000_0001, "CTRL");
        // identification ignores writes
        wb_write(wfg_reg_pkg::adr_id, 32'hFFFF_FFFF);
        wb_write(wfg_reg_pkg::adr_reginfo, 32'h0000_0000);
        expect_read(wfg_reg_pkg::adr_id,
                    {16'h0, wfg_reg_pkg::version, wfg_reg_pkg::peripheral_type}, "ID");
        expect_read(wfg_reg_pkg::adr_reginfo, {14'h0, wfg_reg_pkg::reginfo_date}, "REGINFO");
        wb_write(wfg_reg_pkg::adr_ctrl, 32'h0);
        wait_drained();

        // near 2.0 gain, clamps at the top then at the bottom
        configure(16'h0C00, 16'h7FFF, 18'sd100000);
        wait_samples(n_gain);
        if (sat_hi == 0) begin
            bus_errors++;
            $display("upper saturation was never reached");
        end
        configure(16'h0C00, 16'h7FFF, -18'sd100000);
        wait_samples(n_gain);
        if (sat_lo == 0) begin
            bus_errors++;
            $display("lower saturation was never reached");
        end

        // random back-pressure from here on
        ready_random <= 1'b1;
        configure(16'h0337, 16'h3000, 18'sd1234);
        holds_before = holds;
        wait_samples(n_bp);
        if (holds == holds_before) begin
            bus_errors++;
            $display("no sample was ever stalled by back-pressure");
        end

        // disable mid-stream, new increment, must restart at phase 0
        configure(16'h2000, wfg_reg_pkg::gain_rst, wfg_reg_pkg::offset_rst);
        expect_read(wfg_reg_pkg::adr_inc, 32'h0000_2000, "INC");
        wait_samples(n_restart);

        $display("%0d samples checked, %0d sample errors, %0d bus errors",
                 checked, sample_errors, bus_errors);
        if (sample_errors == 0 && bus_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
common/wfg_reg_pkg.sv
common/wfg_sine_pkg.sv
logic/wfg_stim_sine_scale.sv
wfg_stim_sine/wfg_stim_sine_wishbone_reg.sv
wfg_stim_sine/wfg_stim_sine_cordic.sv
wfg_stim_sine/wfg_stim_sine_top.sv
testbench/wfg_stim_sine_tb.sv

//--- wfg_stim_sine/wfg_stim_sine_cordic.sv
// sine rotator
// phase accumulator feeding a 16-step iterative CORDIC, one sample per handshake
`timescale 1ns/10ps

module wfg_stim_sine_cordic (
    input  logic                 wb_clk_i,
    input  logic                 wb_rst_i,
    input  logic                 en_i,
    input  wfg_sine_pkg::phase_t inc_i,
    output wfg_sine_pkg::sine_t  sin_o,
    output logic                 sin_valid_o,
    input  logic                 sin_ready_i
);

    // x and y carry guard bits below the Q1.16 point
    localparam int xy_w = $bits(wfg_sine_pkg::sine_t) + wfg_sine_pkg::cordic_guard;
    localparam logic signed [xy_w-1:0] x_init =
        xy_w'(wfg_sine_pkg::cordic_k_init << wfg_sine_pkg::cordic_guard);
    // half an lsb of the output, for rounding
    localparam logic signed [xy_w-1:0] rnd_half =
        xy_w'(1 << (wfg_sine_pkg::cordic_guard - 1));
    localparam logic [3:0] iter_last = 4'(wfg_sine_pkg::cordic_iter - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_fold,
        st_rotate,
        st_round,
        st_hold
    } state_t;

    state_t                 state;
    wfg_sine_pkg::phase_t   phase;
    wfg_sine_pkg::phase_t   phase_lat;
    logic [3:0]             iter;
    logic                   neg;
    logic [1:0]             quad;
    logic signed [17:0]     angle;
    logic signed [xy_w-1:0] x;
    logic signed [xy_w-1:0] y;
    logic signed [17:0]     z;
    logic signed [xy_w-1:0] x_sh;
    logic signed [xy_w-1:0] y_sh;
    logic signed [17:0]     atan;
    logic signed [xy_w-1:0] y_rnd;
    logic signed [xy_w-1:0] y_out;

    // fold into 0..90 degrees
    // odd quadrants mirror about 90, upper half negates at the end
    assign quad  = phase_lat[15:14];
    assign angle = quad[0] ? 18'sd32768 - $signed({3'b000, phase_lat[14:0]})
                           : $signed({3'b000, phase_lat[14:0]});

    // one micro-rotation
    assign x_sh = x >>> iter;
    assign y_sh = y >>> iter;
    assign atan = $signed({2'b00, wfg_sine_pkg::cordic_atan[iter]});

    // round off the guard bits, then apply the sign
    assign y_rnd = (y + rnd_half) >>> wfg_sine_pkg::cordic_guard;
    assign y_out = neg ? -y_rnd : y_rnd;

    // control: fold 1 cycle, rotate 16, round 1
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state       <= st_idle;
            phase       <= '0;
            iter        <= '0;
            sin_valid_o <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (en_i) begin
                        state <= st_fold;
                    end else begin
                        // disabled, restart from zero
                        phase <= '0;
                    end
                end
                st_fold: begin
                    iter  <= '0;
                    state <= st_rotate;
                end
                st_rotate: begin
                    iter <= iter + 4'd1;
                    if (iter == iter_last) begin
                        state <= st_round;
                    end
                end
                st_round: begin
                    sin_valid_o <= 1'b1;
                    state       <= st_hold;
                end
                st_hold: begin
                    // step the phase only once the sample is taken
                    if (sin_ready_i) begin
                        sin_valid_o <= 1'b0;
                        phase       <= phase + inc_i;
                        state       <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge wb_clk_i) begin
        case (state)
            st_idle: begin
                phase_lat <= phase;
            end
            st_fold: begin
                x   <= x_init;
                y   <= '0;
                z   <= angle;
                neg <= quad[1];
            end
            st_rotate: begin
                // residual angle sign picks the direction
                if (z >= 0) begin
                    x <= x - y_sh;
                    y <= y + x_sh;
                    z <= z - atan;
                end else begin
                    x <= x + y_sh;
                    y <= y - x_sh;
                    z <= z + atan;
                end
            end
            st_round: begin
                sin_o <= y_out[$bits(wfg_sine_pkg::sine_t)-1:0];
            end
            default: begin
            end
        endcase
    end

    // waiting sample is frozen
    a_sin_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        sin_valid_o && !sin_ready_i |=> sin_valid_o && $stable(sin_o));

endmodule

//--- wfg_stim_sine/wfg_stim_sine_top.sv
// sine stimulus generator top
// wishbone register file, CORDIC rotator and scaling stage
`timescale 1ns/10ps

module wfg_stim_sine_top #(
    parameter int BUSW = 32
) (
    input  logic                  wb_clk_i,
    input  logic                  wb_rst_i,
    input  logic                  wbs_stb_i,
    input  logic                  wbs_cyc_i,
    input  logic                  wbs_we_i,
    input  logic [(BUSW/8-1):0]   wbs_sel_i,
    input  logic [(BUSW-1):0]     wbs_dat_i,
    input  logic [(BUSW-1):0]     wbs_adr_i,
    output logic                  wbs_ack_o,
    output logic [(BUSW-1):0]     wbs_dat_o,
    output wfg_sine_pkg::sample_t sample_o,
    output logic                  sample_valid_o,
    input  logic                  sample_ready_i
);

    wfg_reg_pkg::wfg_cfg_t cfg;
    wfg_sine_pkg::sine_t   sin;
    logic                  sin_valid;
    logic                  sin_ready;

    // configuration registers
    wfg_stim_sine_wishbone_reg #(
        .BUSW(BUSW)
    ) wfg_stim_sine_wishbone_reg_i (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .wbs_stb_i(wbs_stb_i),
        .wbs_cyc_i(wbs_cyc_i),
        .wbs_we_i (wbs_we_i),
        .wbs_sel_i(wbs_sel_i),
        .wbs_dat_i(wbs_dat_i),
        .wbs_adr_i(wbs_adr_i),
        .wbs_ack_o(wbs_ack_o),
        .wbs_dat_o(wbs_dat_o),
        .cfg_o    (cfg)
    );

    // phase and sine
    wfg_stim_sine_cordic wfg_stim_sine_cordic_i (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .en_i       (cfg.en),
        .inc_i      (cfg.inc),
        .sin_o      (sin),
        .sin_valid_o(sin_valid),
        .sin_ready_i(sin_ready)
    );

    // gain, offset, output handshake
    wfg_stim_sine_scale wfg_stim_sine_scale_i (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .sin_i         (sin),
        .sin_valid_i   (sin_valid),
        .gain_i        (cfg.gain),
        .offset_i      (cfg.offset),
        .sin_ready_o   (sin_ready),
        .sample_o      (sample_o),
        .sample_valid_o(sample_valid_o),
        .sample_ready_i(sample_ready_i)
    );

endmodule

//--- wfg_stim_sine/wfg_stim_sine_wishbone_reg.sv
// sine stimulus register file
// wishbone classic slave holding the generator configuration
`timescale 1ns/10ps

module wfg_stim_sine_wishbone_reg #(
    parameter int BUSW = 32
) (
    input  logic                  wb_clk_i,
    input  logic                  wb_rst_i,
    input  logic                  wbs_stb_i,
    input  logic                  wbs_cyc_i,
    input  logic                  wbs_we_i,
    input  logic [(BUSW/8-1):0]   wbs_sel_i,
    input  logic [(BUSW-1):0]     wbs_dat_i,
    input  logic [(BUSW-1):0]     wbs_adr_i,
    output logic                  wbs_ack_o,
    output logic [(BUSW-1):0]     wbs_dat_o,
    output wfg_reg_pkg::wfg_cfg_t cfg_o
);

    // new access accepted
    logic acc;
    // write strobe, same edge as the ack
    logic wr_en;

    wfg_reg_pkg::wfg_cfg_t cfg_q;

    // only take a new access while no ack is out
    // so each strobe gets exactly one ack pulse
    assign acc   = wbs_stb_i && wbs_cyc_i && !wbs_ack_o;
    assign wr_en = acc && wbs_we_i;

    // ack and writable fields
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_ack_o    <= 1'b0;
            cfg_q.en     <= wfg_reg_pkg::ctrl_en_rst;
            cfg_q.inc    <= wfg_reg_pkg::inc_rst;
            cfg_q.gain   <= wfg_reg_pkg::gain_rst;
            cfg_q.offset <= wfg_reg_pkg::offset_rst;
        end else begin
            wbs_ack_o <= acc;
            if (wr_en) begin
                // low data bits only, byte selects are not decoded
                case (wbs_adr_i)
                    BUSW'(wfg_reg_pkg::adr_ctrl): begin
                        cfg_q.en <= wbs_dat_i[0];
                    end
                    BUSW'(wfg_reg_pkg::adr_inc): begin
                        cfg_q.inc <= wbs_dat_i[15:0];
                    end
                    BUSW'(wfg_reg_pkg::adr_gain): begin
                        cfg_q.gain <= wbs_dat_i[15:0];
                    end
                    BUSW'(wfg_reg_pkg::adr_offset): begin
                        cfg_q.offset <= $signed(wbs_dat_i[17:0]);
                    end
                    // ID and REGINFO fall through, read only
                    default: begin
                    end
                endcase
            end
        end
    end

    // read mux, straight from the address
    // master samples it while ack is high
    always_comb begin
        wbs_dat_o = '0;
        case (wbs_adr_i)
            BUSW'(wfg_reg_pkg::adr_ctrl): begin
                wbs_dat_o[0] = cfg_q.en;
            end
            BUSW'(wfg_reg_pkg::adr_inc): begin
                wbs_dat_o[15:0] = cfg_q.inc;
            end
            BUSW'(wfg_reg_pkg::adr_gain): begin
                wbs_dat_o[15:0] = cfg_q.gain;
            end
            BUSW'(wfg_reg_pkg::adr_offset): begin
                // raw field bits, no sign extension on the bus
                wbs_dat_o[17:0] = cfg_q.offset;
            end
            BUSW'(wfg_reg_pkg::adr_reginfo): begin
                wbs_dat_o[17:0] = wfg_reg_pkg::reginfo_date;
            end
            BUSW'(wfg_reg_pkg::adr_id): begin
                wbs_dat_o[15:8] = wfg_reg_pkg::version;
                wbs_dat_o[7:0]  = wfg_reg_pkg::peripheral_type;
            end
            // unmapped
            default: begin
                wbs_dat_o = '0;
            end
        endcase
    end

    assign cfg_o = cfg_q;

    // ack never stretches over two cycles
    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wbs_ack_o |=> !wbs_ack_o);

    // every ack answers a strobe from the cycle before
    a_ack_cause: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wbs_ack_o |-> $past(wbs_stb_i && wbs_cyc_i));

endmodule
